// ==== rtl/spi_flash_pkg.sv ====
// Shared constants and bus structs of the serial-flash read engine.
// Only the plain 03h read is supported, so there are no dummy cycles after the address.
// A request covers 1 to 16 words of 32 bits, which is 4 to 64 data bytes.
package spi_flash_pkg;

	localparam logic [7:0] op_read = 8'h03;	// standard read, no dummy cycles
	localparam int addr_w = 24;	// 3-byte addressing only
	localparam int word_w = 32;	// delivered word width

	// user read request, start is a one-cycle strobe
	typedef struct packed {
		logic              start;
		logic [addr_w-1:0] addr;	// first byte address
		logic [3:0]        n_words_m1;	// words minus one
	} rd_req_t;

	// sequencer to byte engine
	typedef struct packed {
		logic       start;	// one-cycle strobe, taken in idle only
		logic [7:0] tx;	// byte for mosi, msb first
	} byte_req_t;

	// byte engine back to sequencer and packer
	typedef struct packed {
		logic       done;	// one-cycle strobe
		logic [7:0] rx;	// valid together with done
	} byte_rsp_t;

	// output word, little-endian packed
	typedef struct packed {
		logic              valid;	// one-cycle strobe, no back-pressure
		logic [word_w-1:0] data;	// first flash byte in bits 7:0
	} rd_word_t;

endpackage

// ==== rtl/spi_master.sv ====
// Byte-wide SPI master with CPOL/CPHA set by parameter.
// Each sclk half-period lasts sclk_div+2 cycles. Hold sclk_div stable while a byte runs.
// byte_req.start is accepted in idle only. byte_rsp.done pulses once per byte.
`timescale 1ns/100ps
module spi_master #(
	parameter bit cpol = 1'b1,	// sclk idle level
	parameter bit cpha = 1'b1	// 0: sample leading edge, 1: sample trailing edge
) (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  spi_flash_pkg::byte_req_t byte_req,	// start strobe and tx byte
	output spi_flash_pkg::byte_rsp_t byte_rsp,	// done strobe and rx byte
	input  logic [15:0]              sclk_div,	// half-period minus two
	output logic                     sclk,
	output logic                     mosi,
	input  logic                     miso
);

	typedef enum logic [2:0] {
		s_idle,	// wait for start
		s_half,	// half-period wait before an edge
		s_edge,	// one cycle, sclk toggles
		s_last,	// trailing half-period after edge 15
		s_ack,	// capture rx
		s_finish	// done strobe
	} state_t;

	state_t      state;
	logic [15:0] cnt_clk;	// cycles inside a half-period
	logic [3:0]  cnt_edge;	// sclk edges already made, 0..15
	logic [7:0]  mosi_shift;
	logic [7:0]  miso_shift;
	logic [7:0]  rx_q;	// byte handed out with done
	logic        shift_tx;
	logic        sample_rx;

	// mode 0/2 launch on trailing edges, mode 1/3 on leading edges after the first
	assign shift_tx = (state == s_edge) &&
		(cpha ? (cnt_edge != 4'd0 && !cnt_edge[0]) : cnt_edge[0]);
	assign sample_rx = (state == s_edge) && (cpha ? cnt_edge[0] : !cnt_edge[0]);

	assign mosi = mosi_shift[7];	// msb first
	assign byte_rsp = '{done: (state == s_finish), rx: rx_q};

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle:
					if (byte_req.start)
						state <= s_half;
				s_half:
					if (cnt_clk == sclk_div)
						state <= s_edge;
				s_edge:
					if (cnt_edge == 4'd15)	// 16th edge, sclk back at cpol
						state <= s_last;
					else
						state <= s_half;
				s_last:
					if (cnt_clk == sclk_div)
						state <= s_ack;
				s_ack:
					state <= s_finish;
				default:
					state <= s_idle;	// s_finish
			endcase
		end
	end

	// half-period timer, zero outside the wait states
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_clk <= 16'd0;
		else if (state == s_half || state == s_last)
			cnt_clk <= cnt_clk + 16'd1;
		else
			cnt_clk <= 16'd0;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_edge <= 4'd0;
		else if (state == s_idle)
			cnt_edge <= 4'd0;
		else if (state == s_edge)
			cnt_edge <= cnt_edge + 4'd1;	// wraps to 0 after edge 15
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			sclk <= cpol;	// idle level straight out of reset
		else if (state == s_idle)
			sclk <= cpol;
		else if (state == s_edge)
			sclk <= ~sclk;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			mosi_shift <= 8'd0;	// mosi low after reset
		else if (state == s_idle && byte_req.start)
			mosi_shift <= byte_req.tx;	// bit 7 on the pin before the first edge
		else if (shift_tx)
			mosi_shift <= {mosi_shift[6:0], 1'b0};
	end

	always_ff @(posedge sys_clk) begin
		if (sample_rx)
			miso_shift <= {miso_shift[6:0], miso};	// 8 samples fill the byte
		if (state == s_ack)
			rx_q <= miso_shift;
	end

endmodule

// ==== rtl/flash_read_seq.sv ====
// Frames one flash read: cs_n low, opcode 03h, three address bytes, then 00h data bytes.
// rd_req is taken only while busy is low. cs_n and busy release in the packer_done cycle.
// A request in that same cycle starts a new frame, so cs_n is high for one cycle only.
`timescale 1ns/100ps
module flash_read_seq (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  spi_flash_pkg::rd_req_t   rd_req,
	output spi_flash_pkg::byte_req_t byte_req,	// to byte engine
	input  spi_flash_pkg::byte_rsp_t byte_rsp,	// from byte engine
	input  logic                     packer_done,	// last word delivered
	output logic                     data_phase,	// high while data bytes run
	output logic [3:0]               n_words_m1,	// latched count for the packer
	output logic                     cs_n,
	output logic                     busy
);
	import spi_flash_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_open,	// cs_n just fell, opcode goes next
		s_wait,	// byte in flight
		s_drain	// all bytes sent, wait for the packer
	} state_t;

	state_t            state;
	logic              cs_n_q;
	logic              busy_q;
	logic              start_q;	// byte start strobe
	logic [7:0]        tx_q;
	logic [addr_w-1:0] addr_q;
	logic [3:0]        n_q;
	logic [6:0]        byte_idx;	// bytes issued in this frame, up to 68
	logic [6:0]        byte_total;	// 4 header + 4 per word
	logic [7:0]        next_tx;
	logic              accept;
	logic              issue;
	logic              last_byte;

	assign busy = busy_q & ~packer_done;	// drops with done
	assign cs_n = cs_n_q | packer_done;	// rises with done
	assign accept = rd_req.start & ~busy;	// strobe while busy is dropped
	assign byte_total = {1'b0, n_q, 2'b00} + 7'd8;
	assign last_byte = (byte_idx == byte_total);
	assign issue = (state == s_open) ||
		(state == s_wait && byte_rsp.done && !last_byte);	// next byte right after done
	assign data_phase = busy_q && (byte_idx > 7'd4);	// first data byte issued
	assign n_words_m1 = n_q;
	assign byte_req = '{start: start_q, tx: tx_q};

	// byte to send for the current position in the frame
	always_comb begin
		case (byte_idx)
			7'd0:    next_tx = op_read;
			7'd1:    next_tx = addr_q[23:16];	// address msb first
			7'd2:    next_tx = addr_q[15:8];
			7'd3:    next_tx = addr_q[7:0];
			default: next_tx = 8'h00;	// dummy out, data in
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= s_idle;
			cs_n_q <= 1'b1;
			busy_q <= 1'b0;
			start_q <= 1'b0;
			byte_idx <= 7'd0;
		end else begin
			start_q <= issue;	// single-cycle strobe
			if (accept) begin
				state <= s_open;
				cs_n_q <= 1'b0;	// cs_n low one cycle after the request
				busy_q <= 1'b1;
				byte_idx <= 7'd0;
			end else begin
				case (state)
					s_open:
						state <= s_wait;
					s_wait:
						if (byte_rsp.done && last_byte)
							state <= s_drain;
					s_drain:
						if (packer_done) begin
							state <= s_idle;
							cs_n_q <= 1'b1;
							busy_q <= 1'b0;
						end
					default:
						state <= s_idle;
				endcase
				if (issue)
					byte_idx <= byte_idx + 7'd1;
			end
		end
	end

	// request fields and tx byte, loaded before first use
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			addr_q <= rd_req.addr;
			n_q <= rd_req.n_words_m1;
		end
		if (issue)
			tx_q <= next_tx;
	end

endmodule

// ==== rtl/read_word_packer.sv ====
// Packs data bytes little-endian into 32-bit words.
// Valid is registered one cycle after each fourth data byte. There is no back-pressure.
// done strobes one cycle after word n_words_m1+1.
`timescale 1ns/100ps
module read_word_packer (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  spi_flash_pkg::byte_rsp_t byte_rsp,	// received bytes
	input  logic                     data_phase,	// marks data bytes
	input  logic [3:0]               n_words_m1,	// held through the frame
	output spi_flash_pkg::rd_word_t  rd_word,
	output logic                     done
);
	import spi_flash_pkg::*;

	logic [word_w-1:0] word_q;	// shift toward bit 0, first byte ends in 7:0
	logic [1:0]        byte_cnt;	// byte position inside the word
	logic [3:0]        word_cnt;	// words delivered so far
	logic              valid_q;
	logic              last_q;	// word just delivered is the final one
	logic              done_q;
	logic              take;

	assign take = data_phase & byte_rsp.done;
	assign rd_word = '{valid: valid_q, data: word_q};	// data stable until the next byte
	assign done = done_q;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			byte_cnt <= 2'd0;
			word_cnt <= 4'd0;
			valid_q <= 1'b0;
			last_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			valid_q <= take && (byte_cnt == 2'd3);
			done_q <= valid_q && last_q;	// one cycle after the last valid
			if (!data_phase) begin
				byte_cnt <= 2'd0;	// fresh frame
				word_cnt <= 4'd0;
				last_q <= 1'b0;
			end else if (take) begin
				byte_cnt <= byte_cnt + 2'd1;
				if (byte_cnt == 2'd3) begin
					word_cnt <= word_cnt + 4'd1;
					last_q <= (word_cnt == n_words_m1);
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take)
			word_q <= {byte_rsp.rx, word_q[word_w-1:8]};	// new byte enters at the top
	end

endmodule

// ==== rtl/spi_flash_reader.sv ====
// Serial-flash read engine, top level. Only the plain 03h read is supported.
// Every rd_word.valid must be taken when it appears, because there is no back-pressure.
// sclk_div sets the sclk half-period as sclk_div+2 cycles. Hold it stable while busy.
`timescale 1ns/100ps
module spi_flash_reader #(
	parameter bit cpol = 1'b1,	// sclk idle level
	parameter bit cpha = 1'b1	// sample edge select
) (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  spi_flash_pkg::rd_req_t  rd_req,	// ignored while busy
	input  logic [15:0]             sclk_div,
	output logic                    busy,
	output spi_flash_pkg::rd_word_t rd_word,
	output logic                    done,	// end of transfer strobe
	output logic                    cs_n,
	output logic                    sclk,
	output logic                    mosi,
	input  logic                    miso
);
	import spi_flash_pkg::*;

	byte_req_t  byte_req;
	byte_rsp_t  byte_rsp;
	logic       data_phase;
	logic [3:0] n_words_m1;	// latched in the sequencer

	flash_read_seq flash_read_seq_inst (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rd_req      (rd_req),
		.byte_req    (byte_req),
		.byte_rsp    (byte_rsp),
		.packer_done (done),	// packer done also closes the frame
		.data_phase  (data_phase),
		.n_words_m1  (n_words_m1),
		.cs_n        (cs_n),
		.busy        (busy)
	);

	spi_master #(
		.cpol (cpol),
		.cpha (cpha)
	) spi_master_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_req  (byte_req),
		.byte_rsp  (byte_rsp),
		.sclk_div  (sclk_div),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso)
	);

	read_word_packer read_word_packer_inst (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_rsp   (byte_rsp),
		.data_phase (data_phase),
		.n_words_m1 (n_words_m1),
		.rd_word    (rd_word),
		.done       (done)
	);

endmodule

// ==== include/flash_pattern.svh ====
// Data pattern of the flash model, used by the testbench only.
// The byte at an address is its low byte XOR its middle byte XOR 3Ch.
`ifndef FLASH_PATTERN_SVH
`define FLASH_PATTERN_SVH

// byte stored at a 24-bit flash address
function automatic logic [7:0] flash_byte(input logic [23:0] addr);
	return addr[7:0] ^ addr[15:8] ^ 8'h3c;	// addr[23:16] has no effect
endfunction

`endif

// ==== bench/spi_flash_model.sv ====
// Read-only SPI flash model for the testbench. It knows only the 03h read.
// It samples mosi and shifts miso on the sample edge of the given mode.
// Data bytes come from flash_byte, and the address wraps at 24 bits.
`timescale 1ns/100ps
`include "flash_pattern.svh"
module spi_flash_model #(
	parameter bit cpol = 1'b1,
	parameter bit cpha = 1'b1
) (
	input  logic        cs_n,
	input  logic        sclk,
	input  logic        mosi,
	output logic        miso,
	output logic [7:0]  opcode_seen,	// first byte of the last frame
	output logic [23:0] addr_seen	// address bytes of the last frame
);

	logic [7:0]  in_shift;
	logic [7:0]  out_shift;	// msb is on miso
	logic [23:0] rd_addr;	// next byte to serve
	int          bit_cnt;
	int          byte_cnt;

	assign miso = out_shift[7];

	initial begin
		in_shift = 8'h00;
		out_shift = 8'h00;
		rd_addr = 24'h0;
		bit_cnt = 0;
		byte_cnt = 0;
		opcode_seen = 8'h00;
		addr_seen = 24'h0;
	end

	// one whole byte received on mosi
	task automatic take_byte();
		case (byte_cnt)
			0: opcode_seen = in_shift;
			1: rd_addr[23:16] = in_shift;	// msb first
			2: rd_addr[15:8] = in_shift;
			3: begin
				rd_addr[7:0] = in_shift;
				addr_seen = rd_addr;
			end
			default: ;	// dummy byte during data
		endcase
		if (byte_cnt >= 3) begin
			out_shift = flash_byte(rd_addr);	// ready before the next first edge
			rd_addr = rd_addr + 24'd1;
		end
		byte_cnt++;
	endtask

	always @(negedge cs_n) begin
		bit_cnt = 0;	// new frame
		byte_cnt = 0;
		out_shift = 8'h00;
		opcode_seen = 'x;	// unknown until this frame sends them
		addr_seen = 'x;
	end

	// rising edge samples when cpol equals cpha, falling edge otherwise
	always @(sclk) begin
		if (!cs_n && sclk == (cpol == cpha)) begin
			in_shift = {in_shift[6:0], mosi};
			out_shift = {out_shift[6:0], 1'b0};	// next bit after the master sampled
			bit_cnt++;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				take_byte();
			end
		end
	end

endmodule

// ==== bench/spi_flash_reader_asserts.sv ====
// Protocol assertions on the reader top level, attached by bind.
// They are off during reset.
`timescale 1ns/100ps
module spi_flash_reader_asserts #(
	parameter bit cpol = 1'b1
) (
	input logic                    sys_clk,
	input logic                    sys_rst_n,
	input logic                    cs_n,
	input logic                    sclk,
	input logic                    busy,
	input logic                    done,
	input spi_flash_pkg::rd_word_t rd_word
);

	// chip select only inside a transfer
	cs_low_needs_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!cs_n |-> busy) else $error("cs_n low while not busy");

	// sclk parked at its idle level between transfers
	sclk_idle_level: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!busy |-> sclk == cpol) else $error("sclk off idle level");

	strobes_apart: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rd_word.valid && done)) else $error("valid and done together");

endmodule

bind spi_flash_reader spi_flash_reader_asserts #(.cpol(cpol)) spi_flash_reader_asserts_inst (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.cs_n      (cs_n),
	.sclk      (sclk),
	.busy      (busy),
	.done      (done),
	.rd_word   (rd_word)
);

// ==== bench/spi_flash_reader_tb.sv ====
// Testbench of the flash reader in SPI mode 3. Inputs change on the falling edge.
// Fixed rows come first, then rows built from LFSR bits with a fixed seed.
`timescale 1ns/100ps
`include "flash_pattern.svh"
module spi_flash_reader_tb;
	import spi_flash_pkg::*;

	localparam bit cpol = 1'b1;
	localparam bit cpha = 1'b1;
	localparam int n_rows = 8;
	localparam int n_rand = 6;

	typedef struct packed {
		logic [23:0] addr;
		logic [3:0]  n_m1;	// words minus one
		logic [15:0] div;	// sclk_div for this row
		logic        poke;	// strobe a second request while busy
	} row_t;

	row_t stim_rows [n_rows] = '{
		'{24'h000000, 4'd0, 16'd0, 1'b0},	// single word
		'{24'h012345, 4'd0, 16'd3, 1'b0},
		'{24'h00fffc, 4'd3, 16'd1, 1'b0},	// middle byte carries
		'{24'hfffff0, 4'd15, 16'd0, 1'b0},	// wraps at top of flash
		'{24'h100200, 4'd7, 16'd9, 1'b0},	// slow sclk
		'{24'h0a0b0c, 4'd1, 16'd2, 1'b1},
		'{24'h7fff00, 4'd15, 16'd5, 1'b0},
		'{24'h000103, 4'd2, 16'd0, 1'b1}
	};

	logic        sys_clk;
	logic        sys_rst_n;
	rd_req_t     rd_req;
	logic [15:0] sclk_div;
	logic        busy;
	rd_word_t    rd_word;
	logic        done;
	logic        cs_n;
	logic        sclk;
	logic        mosi;
	logic        miso;
	logic [7:0]  opcode_seen;
	logic [23:0] addr_seen;
	logic [31:0] lfsr_state;
	int          value_errors;
	int          timeouts;

	spi_flash_reader #(.cpol(cpol), .cpha(cpha)) spi_flash_reader_inst (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .rd_req(rd_req), .sclk_div(sclk_div),
		.busy(busy), .rd_word(rd_word), .done(done), .cs_n(cs_n), .sclk(sclk),
		.mosi(mosi), .miso(miso)
	);

	spi_flash_model #(.cpol(cpol), .cpha(cpha)) spi_flash_model_inst (
		.cs_n(cs_n), .sclk(sclk), .mosi(mosi), .miso(miso),
		.opcode_seen(opcode_seen), .addr_seen(addr_seen)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;	// 100 ns period
	end

	// galois step with taps x^32+x^22+x^2+x+1
	function automatic logic next_rand_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
		return out;
	endfunction

	// four pattern bytes with the first in bits 7:0
	function automatic logic [31:0] expected_word(input logic [23:0] base, input int w);
		logic [31:0] word;
		for (int k = 0; k < 4; k++)
			word[8*k +: 8] = flash_byte(base + 24'(4 * w + k));
		return word;
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		value_errors++;
	endtask

	task automatic run_row(input row_t row);
		int   words;
		int   cycles;
		int   limit;
		bit   seen_done;
		logic [31:0] exp;
		words = 0;
		cycles = 0;
		seen_done = 1'b0;
		limit = 68 * (17 * (int'(row.div) + 2) + 8) + 200;	// worst case frame plus margin
		@(negedge sys_clk);
		sclk_div = row.div;
		rd_req = '{start: 1'b1, addr: row.addr, n_words_m1: row.n_m1};
		while (!seen_done && cycles < limit) begin
			@(negedge sys_clk);
			cycles++;
			rd_req.start = 1'b0;
			if (cycles == 1) begin	// one cycle after the request
				if (busy !== 1'b1)
					report_value("busy", 32'd1, {31'd0, busy});
				if (cs_n !== 1'b0)
					report_value("cs_n", 32'd0, {31'd0, cs_n});
			end
			if (row.poke && cycles == 30)	// must be ignored
				rd_req = '{start: 1'b1, addr: ~row.addr, n_words_m1: ~row.n_m1};
			if (rd_word.valid) begin
				exp = expected_word(row.addr, words);
				if (rd_word.data !== exp)
					report_value("rd_word.data", exp, rd_word.data);
				words++;
			end
			if (done)
				seen_done = 1'b1;
		end
		if (!seen_done) begin
			$display("timeout: no done for address %h after %0d cycles", row.addr, cycles);
			timeouts++;
		end else begin
			if (words != int'(row.n_m1) + 1)
				report_value("word count", 32'(int'(row.n_m1) + 1), 32'(words));
			if (busy !== 1'b0)	// released in the done cycle
				report_value("busy", 32'd0, {31'd0, busy});
			if (cs_n !== 1'b1)
				report_value("cs_n", 32'd1, {31'd0, cs_n});
			for (int i = 0; i < 40; i++) begin	// quiet window after done
				@(negedge sys_clk);
				if (rd_word.valid !== 1'b0)
					report_value("rd_word.valid", 32'd0, {31'd0, rd_word.valid});
				if (done !== 1'b0)
					report_value("done", 32'd0, {31'd0, done});
				if (busy !== 1'b0)
					report_value("busy", 32'd0, {31'd0, busy});
			end
			if (cs_n !== 1'b1)
				report_value("cs_n", 32'd1, {31'd0, cs_n});
			if (sclk !== cpol)
				report_value("sclk", {31'd0, cpol}, {31'd0, sclk});
			if (opcode_seen !== op_read)
				report_value("opcode_seen", {24'd0, op_read}, {24'd0, opcode_seen});
			if (addr_seen !== row.addr)
				report_value("addr_seen", {8'd0, row.addr}, {8'd0, addr_seen});
		end
	endtask

	initial begin
		row_t row;
		value_errors = 0;
		timeouts = 0;
		lfsr_state = 32'hae4f_b84d;
		sys_rst_n = 1'b0;
		rd_req = '0;
		sclk_div = 16'd0;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		if (cs_n !== 1'b1)	// idle levels after reset
			report_value("cs_n", 32'd1, {31'd0, cs_n});
		if (sclk !== cpol)
			report_value("sclk", {31'd0, cpol}, {31'd0, sclk});
		if (busy !== 1'b0)
			report_value("busy", 32'd0, {31'd0, busy});
		if (mosi !== 1'b0)
			report_value("mosi", 32'd0, {31'd0, mosi});
		for (int r = 0; r < n_rows; r++)
			run_row(stim_rows[r]);
		for (int r = 0; r < n_rand; r++) begin
			row = '0;
			for (int i = 0; i < 24; i++)
				row.addr = {row.addr[22:0], next_rand_bit()};
			for (int i = 0; i < 4; i++)
				row.n_m1 = {row.n_m1[2:0], next_rand_bit()};
			for (int i = 0; i < 2; i++)
				row.div = {row.div[14:0], next_rand_bit()};	// keeps sclk fast
			run_row(row);
		end
		$display("summary: %0d value errors, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== spi_flash_reader.f ====
+incdir+include
rtl/spi_flash_pkg.sv
rtl/spi_master.sv
rtl/flash_read_seq.sv
rtl/read_word_packer.sv
rtl/spi_flash_reader.sv
bench/spi_flash_model.sv
bench/spi_flash_reader_asserts.sv
bench/spi_flash_reader_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = spi_flash_reader_tb
FILELIST  = spi_flash_reader.f
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)
